/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mc_cpu
FILELIST  := mc_cpu.f
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/mc_cpu_vectors.txt */
# I word | D index word | R index (xorshift fill) | S addr data
# T pc reg value gap | L pc reg data_index gap   (gap in cycles, 0 = unchecked)
D 42 00000000
R 43
I 142468a1
I 02bfec02
I 02801c03
I 00100c24
I 00110865
I 00120c46
I 00128c47
I 00140c28
I 00148829
I 00150c2a
I 0015888b
I 0040906c
I 0044a04d
I 0048844e
I 02819060
I 00100c0f
I 02840010
I 29802201
I 28802211
I 28803212
I 5800086f
I 02800413
I 5c00086f
I 02815414
I 58000843
I 5c000843
I 02800415
I 50000800
I 02800416
I 54000c00
I 02800417
I 02800418
I 4c001039
I 0280041a
I 0010033b
I 50000000
S 00000108 12345000
T 1c000000 1 12345000 0
T 1c000004 2 fffffffb 4
T 1c000008 3 00000007 4
T 1c00000c 4 12345007 4
T 1c000010 5 0000000c 4
T 1c000014 6 00000001 4
T 1c000018 7 00000000 4
T 1c00001c 8 edcbaff8 4
T 1c000020 9 12345000 4
T 1c000024 a 12345007 4
T 1c000028 b edcbaffc 4
T 1c00002c c 00000070 4
T 1c000030 d 00ffffff 4
T 1c000034 e fffffffd 4
T 1c000038 0 0000006b 4
T 1c00003c f 00000007 4
T 1c000040 10 00000100 4
T 1c000048 11 12345000 9
L 1c00004c 12 43 5
T 1c00005c 14 00000055 8
T 1c000074 1 1c000078 10
T 1c000080 19 1c000084 4
T 1c000088 1b 1c000084 4

/* bench/tb_mc_cpu.sv */
`timescale 1ns/1ps

module tb_mc_cpu;

    localparam cpu_cfg_pkg::word_t RESET_PC = 32'h1c00_0000;
    localparam int WB_TIMEOUT = 50;

    logic                   clk;
    logic                   resetn;
    logic                   inst_sram_we;
    cpu_cfg_pkg::word_t     inst_sram_addr, inst_sram_wdata, inst_sram_rdata;
    logic                   data_sram_we;
    cpu_cfg_pkg::word_t     data_sram_addr, data_sram_wdata, data_sram_rdata;
    cpu_cfg_pkg::word_t     debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]             debug_wb_rf_we;
    cpu_cfg_pkg::reg_addr_t debug_wb_rf_wnum;

    cpu_cfg_pkg::word_t imem [256];
    cpu_cfg_pkg::word_t dmem [256];
    cpu_cfg_pkg::word_t exp_pc [$];
    cpu_cfg_pkg::word_t exp_val [$];
    cpu_cfg_pkg::word_t exp_st_addr [$];
    cpu_cfg_pkg::word_t exp_st_data [$];
    int                 exp_reg [$];
    int                 exp_gap [$];
    int                 error_count = 0;
    int                 cycle = 0;
    logic               seen_wb = 1'b0;
    logic               prev_data_we = 1'b0;
    logic               run_active = 1'b0;
    logic [31:0]        rng = 32'hb5e9;

    mc_cpu_top #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .resetn(resetn),
        .inst_sram_we(inst_sram_we), .inst_sram_addr(inst_sram_addr),
        .inst_sram_wdata(inst_sram_wdata), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    // --------------------------------------------------
    // SRAM models
    // --------------------------------------------------
    assign inst_sram_rdata = imem[8'((inst_sram_addr - RESET_PC) >> 2)];
    assign data_sram_rdata = dmem[data_sram_addr[9:2]];

    always @(posedge clk) begin
        if (data_sram_we)
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string why);
        error_count++;
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        int          imem_idx;
        string       line;
        string       tag;
        logic [31:0] a, b, c;
        int          d;
        imem_idx = 0;
        fd = $fopen("bench/mc_cpu_vectors.txt", "r");
        if (fd == 0)
            fail_run("Could not open the vector file bench/mc_cpu_vectors.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %d", tag, a, b, c, d);
                case (tag)
                    "I": begin
                        imem[imem_idx] = a;
                        imem_idx++;
                    end
                    "D": dmem[a[7:0]] = b;
                    "R": begin
                        rng = xorshift32(rng);
                        dmem[a[7:0]] = rng;
                    end
                    "T", "L": begin
                        exp_pc.push_back(a);
                        exp_reg.push_back(int'(b));
                        exp_val.push_back(tag == "L" ? dmem[c[7:0]] : c); // Load of init data
                        exp_gap.push_back(d);
                    end
                    "S": begin
                        exp_st_addr.push_back(a);
                        exp_st_data.push_back(b);
                    end
                    default: fail_run({"Unknown record in the vector file: ", line});
                endcase
            end
        end
        $fclose(fd);
    endtask

    // Stores, strobe width and idle outputs before the first writeback
    always @(negedge clk) begin
        if (run_active) begin
            check_value("inst_sram_we", 32'h0, 32'(inst_sram_we));
            check_value("inst_sram_wdata", 32'h0, inst_sram_wdata);
            if (debug_wb_rf_we != 4'h0 && debug_wb_rf_we != 4'hf)
                fail_run("debug_wb_rf_we is neither all zeros nor all ones");
            if (data_sram_we && !seen_wb)
                fail_run("data_sram_we went high before the first writeback");
            if (data_sram_we && prev_data_we)
                fail_run("data_sram_we stayed high for more than one cycle");
            if (data_sram_we) begin
                if (exp_st_addr.size() == 0)
                    fail_run("Unexpected store on the data SRAM port");
                check_value("store address", exp_st_addr.pop_front(), data_sram_addr);
                check_value("store data", exp_st_data.pop_front(), data_sram_wdata);
            end
            prev_data_we = data_sram_we;
        end
    end

    initial begin
        int k;
        int waited;
        int last_wb;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = 32'ha500_0000 ^ (i * 4); // Address-dependent fill
        end
        resetn = 1'b0;
        load_vectors();

        repeat (4) @(negedge clk);
        resetn = 1'b1;
        check_value("first fetch address", RESET_PC, inst_sram_addr);
        run_active = 1'b1;
        last_wb = 0;

        for (k = 0; k < exp_pc.size(); k++) begin
            waited = 0;
            @(negedge clk);
            while (debug_wb_rf_we != 4'hf) begin
                waited++;
                if (waited >= WB_TIMEOUT)
                    fail_run($sformatf("Timed out waiting for writeback number %0d", k));
                @(negedge clk);
            end
            seen_wb = 1'b1;
            check_value($sformatf("trace %0d pc", k), exp_pc[k], debug_wb_pc);
            check_value($sformatf("trace %0d wnum", k), exp_reg[k], 32'(debug_wb_rf_wnum));
            check_value($sformatf("trace %0d wdata", k), exp_val[k], debug_wb_rf_wdata);
            if (exp_gap[k] != 0)
                check_value($sformatf("trace %0d spacing", k), exp_gap[k], cycle - last_wb);
            last_wb = cycle;
        end

        if (exp_st_addr.size() != 0)
            fail_run("Not every expected store was seen on the data SRAM port");
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* common/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    localparam int WORD_W = 32;
    localparam int RADDR_W = 5;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [RADDR_W-1:0] reg_addr_t;

    // --------------------------------------------------
    // Multicycle sequencer
    // --------------------------------------------------
    typedef enum logic [2:0] {
        IF  = 3'd0,
        ID  = 3'd1,
        EXE = 3'd2,
        MEM = 3'd3,
        WB  = 3'd4
    } seq_state_e;

endpackage

/* common/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    la_isa_pkg::alu_op_e    alu_op;
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    cpu_cfg_pkg::word_t     imm;
    cpu_cfg_pkg::word_t     br_offs;      // Already shifted left by two
    cpu_cfg_pkg::reg_addr_t dest;
    logic                   gr_we;
    logic                   mem_we;
    logic                   res_from_mem;
    la_isa_pkg::inst_kind_e inst_kind;
    logic                   is_beq;
    logic                   is_bne;
    logic                   is_jirl;
    cpu_cfg_pkg::reg_addr_t rf_raddr1;
    cpu_cfg_pkg::reg_addr_t rf_raddr2;

    modport producer (
        output alu_op, src1_is_pc, src2_is_imm, imm, br_offs, dest, gr_we,
               mem_we, res_from_mem, inst_kind, is_beq, is_bne, is_jirl,
               rf_raddr1, rf_raddr2
    );

    modport consumer (
        input  alu_op, src1_is_pc, src2_is_imm, imm, br_offs, dest, gr_we,
               mem_we, res_from_mem, inst_kind, is_beq, is_bne, is_jirl,
               rf_raddr1, rf_raddr2
    );
endinterface

/* common/la_isa_pkg.sv */
package la_isa_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR,  ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // Picks the sequencer path after ID
    typedef enum logic [2:0] {
        KIND_ALU, KIND_LOAD, KIND_STORE, KIND_BRANCH, KIND_LINK
    } inst_kind_e;

    // Opcode bits 31:26
    localparam logic [5:0] OP6_GROUP0 = 6'h00; // reg ops, shifts, addi.w
    localparam logic [5:0] OP6_LU12I  = 6'h05;
    localparam logic [5:0] OP6_LDST   = 6'h0a;
    localparam logic [5:0] OP6_JIRL   = 6'h13;
    localparam logic [5:0] OP6_B      = 6'h14;
    localparam logic [5:0] OP6_BL     = 6'h15;
    localparam logic [5:0] OP6_BEQ    = 6'h16;
    localparam logic [5:0] OP6_BNE    = 6'h17;

    // Bits 25:22 and 21:20
    localparam logic [3:0] OP4_REG3   = 4'h0;
    localparam logic [3:0] OP4_SHIFT  = 4'h1;
    localparam logic [3:0] OP4_LD_W   = 4'h2;
    localparam logic [3:0] OP4_ST_W   = 4'h6;
    localparam logic [3:0] OP4_ADDI   = 4'ha;
    localparam logic [1:0] OP2_REG3   = 2'h1;
    localparam logic [1:0] OP2_SHIFT  = 2'h0;

    // Bits 19:15
    localparam logic [4:0] OP5_ADD    = 5'h00;
    localparam logic [4:0] OP5_SUB    = 5'h02;
    localparam logic [4:0] OP5_SLT    = 5'h04;
    localparam logic [4:0] OP5_SLTU   = 5'h05;
    localparam logic [4:0] OP5_NOR    = 5'h08;
    localparam logic [4:0] OP5_AND    = 5'h09;
    localparam logic [4:0] OP5_OR     = 5'h0a;
    localparam logic [4:0] OP5_XOR    = 5'h0b;
    localparam logic [4:0] OP5_SLLI   = 5'h01;
    localparam logic [4:0] OP5_SRLI   = 5'h09;
    localparam logic [4:0] OP5_SRAI   = 5'h11;

endpackage

/* core/alu.sv */
`timescale 1ns/1ps

module alu (
    input  la_isa_pkg::alu_op_e alu_op,
    input  cpu_cfg_pkg::word_t  alu_src1,
    input  cpu_cfg_pkg::word_t  alu_src2,
    output cpu_cfg_pkg::word_t  alu_result
);
    logic [4:0]         shamt;
    cpu_cfg_pkg::word_t sum, diff;
    logic               lt_signed, lt_unsigned;

    assign shamt = alu_src2[4:0];
    assign sum   = alu_src1 + alu_src2;
    assign diff  = alu_src1 - alu_src2;

    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        case (alu_op)
            la_isa_pkg::ALU_ADD:  alu_result = sum;
            la_isa_pkg::ALU_SUB:  alu_result = diff;
            la_isa_pkg::ALU_SLT:  alu_result = {31'b0, lt_signed};
            la_isa_pkg::ALU_SLTU: alu_result = {31'b0, lt_unsigned};
            la_isa_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            la_isa_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            la_isa_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            la_isa_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            la_isa_pkg::ALU_SLL:  alu_result = alu_src1 << shamt;
            la_isa_pkg::ALU_SRL:  alu_result = alu_src1 >> shamt;
            la_isa_pkg::ALU_SRA:  alu_result = $signed(alu_src1) >>> shamt;
            la_isa_pkg::ALU_LUI:  alu_result = alu_src2; // Already shifted by decode
            default:              alu_result = sum;
        endcase
    end

endmodule

/* core/core_seq.sv */
`timescale 1ns/1ps

module core_seq #(
    parameter cpu_cfg_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    decode_if.consumer             dec,
    output cpu_cfg_pkg::word_t     inst_addr,
    input  cpu_cfg_pkg::word_t     inst_rdata,
    output cpu_cfg_pkg::word_t     inst_reg,
    output cpu_cfg_pkg::reg_addr_t rf_raddr1,
    output cpu_cfg_pkg::reg_addr_t rf_raddr2,
    input  cpu_cfg_pkg::word_t     rf_rdata1,
    input  cpu_cfg_pkg::word_t     rf_rdata2,
    output logic                   rf_we,
    output cpu_cfg_pkg::reg_addr_t rf_waddr,
    output cpu_cfg_pkg::word_t     rf_wdata,
    output la_isa_pkg::alu_op_e    alu_op,
    output cpu_cfg_pkg::word_t     alu_src1,
    output cpu_cfg_pkg::word_t     alu_src2,
    input  cpu_cfg_pkg::word_t     alu_result,
    output logic                   data_we,
    output cpu_cfg_pkg::word_t     data_addr,
    output cpu_cfg_pkg::word_t     data_wdata,
    input  cpu_cfg_pkg::word_t     data_rdata,
    output cpu_cfg_pkg::word_t     wb_pc
);
    cpu_cfg_pkg::seq_state_e state, state_next;
    cpu_cfg_pkg::word_t      pc, ir, npc_q;
    cpu_cfg_pkg::word_t      rj_q, rk_q, alu_q, mem_q;
    cpu_cfg_pkg::word_t      br_target, next_pc;
    logic                    br_taken;

    // --------------------------------------------------
    // Branch resolution in ID, on live register reads
    // --------------------------------------------------
    assign br_target = (dec.is_jirl ? rf_rdata1 : pc) + dec.br_offs;

    always_comb begin
        case (dec.inst_kind)
            la_isa_pkg::KIND_BRANCH: begin
                if (dec.is_beq)
                    br_taken = (rf_rdata1 == rf_rdata2);
                else if (dec.is_bne)
                    br_taken = (rf_rdata1 != rf_rdata2);
                else
                    br_taken = 1'b1; // b
            end
            la_isa_pkg::KIND_LINK: br_taken = 1'b1;
            default:               br_taken = 1'b0;
        endcase
    end

    assign next_pc = br_taken ? br_target : pc + 32'd4;

    always_comb begin
        case (state)
            cpu_cfg_pkg::IF:  state_next = cpu_cfg_pkg::ID;
            cpu_cfg_pkg::ID:  state_next = (dec.inst_kind == la_isa_pkg::KIND_BRANCH) ?
                                           cpu_cfg_pkg::IF : cpu_cfg_pkg::EXE;
            cpu_cfg_pkg::EXE: state_next = (dec.inst_kind == la_isa_pkg::KIND_LOAD ||
                                            dec.inst_kind == la_isa_pkg::KIND_STORE) ?
                                           cpu_cfg_pkg::MEM : cpu_cfg_pkg::WB;
            cpu_cfg_pkg::MEM: state_next = (dec.inst_kind == la_isa_pkg::KIND_LOAD) ?
                                           cpu_cfg_pkg::WB : cpu_cfg_pkg::IF;
            default:          state_next = cpu_cfg_pkg::IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= cpu_cfg_pkg::IF;
            pc      <= RESET_PC;
            data_we <= 1'b0;
        end else begin
            state   <= state_next;
            data_we <= (state == cpu_cfg_pkg::EXE) && dec.mem_we; // High through MEM
            if (state_next == cpu_cfg_pkg::IF)
                pc <= (state == cpu_cfg_pkg::ID) ? next_pc : npc_q;
        end
    end

    // Datapath latches
    always_ff @(posedge clk) begin
        case (state)
            cpu_cfg_pkg::IF: ir <= inst_rdata;
            cpu_cfg_pkg::ID: begin
                rj_q  <= rf_rdata1;
                rk_q  <= rf_rdata2;
                npc_q <= next_pc;
            end
            cpu_cfg_pkg::EXE: begin
                alu_q      <= alu_result; // Also the data address
                data_wdata <= rk_q;
            end
            cpu_cfg_pkg::MEM: mem_q <= data_rdata;
            default: ;
        endcase
    end

    assign inst_addr = pc;
    assign inst_reg  = ir;
    assign rf_raddr1 = dec.rf_raddr1;
    assign rf_raddr2 = dec.rf_raddr2;
    assign alu_op    = dec.alu_op;
    assign alu_src1  = dec.src1_is_pc  ? pc      : rj_q;
    assign alu_src2  = dec.src2_is_imm ? dec.imm : rk_q;
    assign data_addr = alu_q;

    assign rf_we    = (state == cpu_cfg_pkg::WB) && dec.gr_we;
    assign rf_waddr = dec.dest;
    assign rf_wdata = dec.res_from_mem ? mem_q : alu_q;
    assign wb_pc    = pc; // pc only moves on the way back to IF

endmodule

/* core/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  cpu_cfg_pkg::word_t inst_reg,
    decode_if.producer         dec
);
    logic [5:0] op6;
    logic [3:0] op4;
    logic [1:0] op2;
    logic [4:0] op5;
    cpu_cfg_pkg::reg_addr_t rd, rj, rk;
    logic is_reg3, is_shift;
    logic inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli, inst_srli, inst_srai, inst_addi, inst_lu12i;
    logic inst_ld, inst_st, inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;

    assign op6 = inst_reg[31:26];
    assign op4 = inst_reg[25:22];
    assign op2 = inst_reg[21:20];
    assign op5 = inst_reg[19:15];
    assign rd  = inst_reg[4:0];
    assign rj  = inst_reg[9:5];
    assign rk  = inst_reg[14:10];

    assign is_reg3  = op6 == la_isa_pkg::OP6_GROUP0 && op4 == la_isa_pkg::OP4_REG3 &&
                      op2 == la_isa_pkg::OP2_REG3;
    assign is_shift = op6 == la_isa_pkg::OP6_GROUP0 && op4 == la_isa_pkg::OP4_SHIFT &&
                      op2 == la_isa_pkg::OP2_SHIFT;

    assign inst_sub   = is_reg3 && op5 == la_isa_pkg::OP5_SUB;
    assign inst_slt   = is_reg3 && op5 == la_isa_pkg::OP5_SLT;
    assign inst_sltu  = is_reg3 && op5 == la_isa_pkg::OP5_SLTU;
    assign inst_nor   = is_reg3 && op5 == la_isa_pkg::OP5_NOR;
    assign inst_and   = is_reg3 && op5 == la_isa_pkg::OP5_AND;
    assign inst_or    = is_reg3 && op5 == la_isa_pkg::OP5_OR;
    assign inst_xor   = is_reg3 && op5 == la_isa_pkg::OP5_XOR;
    assign inst_slli  = is_shift && op5 == la_isa_pkg::OP5_SLLI;
    assign inst_srli  = is_shift && op5 == la_isa_pkg::OP5_SRLI;
    assign inst_srai  = is_shift && op5 == la_isa_pkg::OP5_SRAI;
    assign inst_addi  = op6 == la_isa_pkg::OP6_GROUP0 && op4 == la_isa_pkg::OP4_ADDI;
    assign inst_lu12i = op6 == la_isa_pkg::OP6_LU12I && !inst_reg[25];
    assign inst_ld    = op6 == la_isa_pkg::OP6_LDST && op4 == la_isa_pkg::OP4_LD_W;
    assign inst_st    = op6 == la_isa_pkg::OP6_LDST && op4 == la_isa_pkg::OP4_ST_W;
    assign inst_jirl  = op6 == la_isa_pkg::OP6_JIRL;
    assign inst_b     = op6 == la_isa_pkg::OP6_B;
    assign inst_bl    = op6 == la_isa_pkg::OP6_BL;
    assign inst_beq   = op6 == la_isa_pkg::OP6_BEQ;
    assign inst_bne   = op6 == la_isa_pkg::OP6_BNE;

    // --------------------------------------------------
    // ALU operation and state path
    // --------------------------------------------------
    always_comb begin
        dec.alu_op = la_isa_pkg::ALU_ADD; // add.w, addi, ld, st and link add
        if (inst_sub)        dec.alu_op = la_isa_pkg::ALU_SUB;
        else if (inst_slt)   dec.alu_op = la_isa_pkg::ALU_SLT;
        else if (inst_sltu)  dec.alu_op = la_isa_pkg::ALU_SLTU;
        else if (inst_and)   dec.alu_op = la_isa_pkg::ALU_AND;
        else if (inst_nor)   dec.alu_op = la_isa_pkg::ALU_NOR;
        else if (inst_or)    dec.alu_op = la_isa_pkg::ALU_OR;
        else if (inst_xor)   dec.alu_op = la_isa_pkg::ALU_XOR;
        else if (inst_slli)  dec.alu_op = la_isa_pkg::ALU_SLL;
        else if (inst_srli)  dec.alu_op = la_isa_pkg::ALU_SRL;
        else if (inst_srai)  dec.alu_op = la_isa_pkg::ALU_SRA;
        else if (inst_lu12i) dec.alu_op = la_isa_pkg::ALU_LUI;

        if (inst_ld)                           dec.inst_kind = la_isa_pkg::KIND_LOAD;
        else if (inst_st)                      dec.inst_kind = la_isa_pkg::KIND_STORE;
        else if (inst_b || inst_beq || inst_bne) dec.inst_kind = la_isa_pkg::KIND_BRANCH;
        else if (inst_bl || inst_jirl)         dec.inst_kind = la_isa_pkg::KIND_LINK;
        else                                   dec.inst_kind = la_isa_pkg::KIND_ALU;
    end

    // Immediates
    always_comb begin
        if (inst_bl || inst_jirl)
            dec.imm = 32'd4; // Link value is pc + 4
        else if (inst_lu12i)
            dec.imm = {inst_reg[24:5], 12'b0};
        else if (inst_slli || inst_srli || inst_srai)
            dec.imm = {27'b0, inst_reg[14:10]};
        else
            dec.imm = {{20{inst_reg[21]}}, inst_reg[21:10]};
    end

    assign dec.br_offs = (inst_b || inst_bl) ?
                         {{4{inst_reg[9]}}, inst_reg[9:0], inst_reg[25:10], 2'b0} :
                         {{14{inst_reg[25]}}, inst_reg[25:10], 2'b0};

    assign dec.src1_is_pc   = inst_bl || inst_jirl;
    assign dec.src2_is_imm  = !(is_reg3 || inst_beq || inst_bne);
    assign dec.dest         = inst_bl ? 5'd1 : rd;
    assign dec.gr_we        = !(inst_st || inst_b || inst_beq || inst_bne);
    assign dec.mem_we       = inst_st;
    assign dec.res_from_mem = inst_ld;
    assign dec.is_beq       = inst_beq;
    assign dec.is_bne       = inst_bne;
    assign dec.is_jirl      = inst_jirl;
    assign dec.rf_raddr1    = rj;
    assign dec.rf_raddr2    = (inst_beq || inst_bne || inst_st) ? rd : rk;

endmodule

/* core/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                   clk,
    input  cpu_cfg_pkg::reg_addr_t raddr1,
    input  cpu_cfg_pkg::reg_addr_t raddr2,
    output cpu_cfg_pkg::word_t     rdata1,
    output cpu_cfg_pkg::word_t     rdata2,
    input  logic                   we,
    input  cpu_cfg_pkg::reg_addr_t waddr,
    input  cpu_cfg_pkg::word_t     wdata
);
    cpu_cfg_pkg::word_t rf [32];

    always_ff @(posedge clk) begin
        if (we)
            rf[waddr] <= wdata;
    end

    // r0 reads zero whatever was written
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* mc_cpu.f */
common/cpu_cfg_pkg.sv
common/la_isa_pkg.sv
common/decode_if.sv
core/alu.sv
core/regfile.sv
core/inst_decoder.sv
core/core_seq.sv
verilog/mc_cpu_top.sv
bench/tb_mc_cpu.sv

/* verilog/mc_cpu_top.sv */
`timescale 1ns/1ps

module mc_cpu_top #(
    parameter cpu_cfg_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic                   clk,
    input  logic                   resetn,
    output logic                   inst_sram_we,
    output cpu_cfg_pkg::word_t     inst_sram_addr,
    output cpu_cfg_pkg::word_t     inst_sram_wdata,
    input  cpu_cfg_pkg::word_t     inst_sram_rdata,
    output logic                   data_sram_we,
    output cpu_cfg_pkg::word_t     data_sram_addr,
    output cpu_cfg_pkg::word_t     data_sram_wdata,
    input  cpu_cfg_pkg::word_t     data_sram_rdata,
    output cpu_cfg_pkg::word_t     debug_wb_pc,
    output logic [3:0]             debug_wb_rf_we,
    output cpu_cfg_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_cfg_pkg::word_t     debug_wb_rf_wdata
);
    logic                   reset;
    cpu_cfg_pkg::word_t     inst_reg;
    cpu_cfg_pkg::reg_addr_t rf_raddr1, rf_raddr2, rf_waddr;
    cpu_cfg_pkg::word_t     rf_rdata1, rf_rdata2, rf_wdata;
    logic                   rf_we;
    la_isa_pkg::alu_op_e    alu_op;
    cpu_cfg_pkg::word_t     alu_src1, alu_src2, alu_result;

    decode_if dec_bus ();

    always_ff @(posedge clk) reset <= ~resetn; // Sync reset from board pin

    core_seq #(.RESET_PC(RESET_PC)) u_seq (
        .clk(clk), .reset(reset), .dec(dec_bus.consumer),
        .inst_addr(inst_sram_addr), .inst_rdata(inst_sram_rdata), .inst_reg(inst_reg),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2), .alu_result(alu_result),
        .data_we(data_sram_we), .data_addr(data_sram_addr),
        .data_wdata(data_sram_wdata), .data_rdata(data_sram_rdata),
        .wb_pc(debug_wb_pc)
    );

    inst_decoder u_dec (.inst_reg(inst_reg), .dec(dec_bus.producer));

    regfile u_rf (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    alu u_alu (.alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2),
               .alu_result(alu_result));

    assign inst_sram_we      = 1'b0;
    assign inst_sram_wdata   = '0;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule
